/* rtl/usb_rx_config.svh */
//////////////////////////////
// constants for the full-speed receiver: sync and reset history,
// crc seeds, polynomials and residues, stuffing limit, pid sentinel
//////////////////////////////
`ifndef USB_RX_CONFIG_SVH
`define USB_RX_CONFIG_SVH

// last six mid-bit samples of a sync, oldest in the top bits: K J K J K K
`define USB_SYNC_HISTORY 12'b01_10_01_10_01_01

// history as if the line had sat at K, so neither SOP nor EOP can match
`define USB_HISTORY_RESET 12'b01_01_01_01_01_01

// crc5 covers token payloads, the residue is what a clean packet leaves behind
`define USB_CRC5_SEED 5'b11111
`define USB_CRC5_POLY 5'b00101
`define USB_CRC5_RESIDUE 5'b01100

// crc16 covers data payloads
`define USB_CRC16_SEED 16'hFFFF
`define USB_CRC16_POLY 16'h8005
`define USB_CRC16_RESIDUE 16'h800D

// the transmitter inserts a zero after this many ones in a row
`define USB_STUFF_LIMIT 6

// bit 8 walks down to bit 0 once eight pid bits have been shifted in
`define USB_PID_SENTINEL 9'b1_0000_0000

`endif

/* rtl/usb_rx_pkg.sv */
//////////////////////////////
// types shared by the stages of the full-speed receiver
//////////////////////////////
package usb_rx_pkg;

  // recovered line symbol, the low two bits are the {D+, D-} pair
  typedef enum logic [2:0] {
    LS_SE0 = 3'b000,
    LS_K   = 3'b001,
    LS_J   = 3'b010,
    LS_DT  = 3'b100
  } line_state_e;

  // packet type as carried in pid bits 1:0
  typedef enum logic [1:0] {
    KIND_SPECIAL   = 2'b00,
    KIND_TOKEN     = 2'b01,
    KIND_HANDSHAKE = 2'b10,
    KIND_DATA      = 2'b11
  } pkt_kind_e;

  typedef logic [3:0]  usb_pid_t;
  typedef logic [6:0]  usb_addr_t;
  typedef logic [3:0]  usb_endp_t;
  typedef logic [10:0] frame_num_t;
  typedef logic [7:0]  rx_byte_t;
  typedef logic [4:0]  crc5_t;
  typedef logic [15:0] crc16_t;

endpackage

/* rtl/usb_rx_line_recovery.sv */
//////////////////////////////
// line symbol recovery from the D+/D- pair with transition settling,
// and bit-phase clock recovery at four samples per bit
//////////////////////////////
`timescale 1ns/1ns

module usb_rx_line_recovery import usb_rx_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        link_reset_i,
  input  logic        usb_dp_i,
  input  logic        usb_dn_i,
  output line_state_e symbol_o,
  output logic        symbol_valid_o,
  output logic        bit_strobe_o
);

  logic [1:0]  pair;
  line_state_e state_q, state_d;
  logic [1:0]  bit_phase_q, bit_phase_d;

  assign pair = {usb_dp_i, usb_dn_i};

  // the two wires of the pair may not flip on the same clock, so any change
  // parks the state in DT for one cycle before the pair is trusted again
  always_comb begin
    state_d = state_q;
    if (state_q == LS_DT) begin
      state_d = line_state_e'({1'b0, pair});
    end else if (pair != state_q[1:0]) begin
      state_d = LS_DT;
    end
  end

  // every DT marks a bit edge, so the phase counter realigns there
  // and free-runs through long runs without transitions
  assign bit_phase_d = (state_q == LS_DT) ? 2'd0 : bit_phase_q + 2'd1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= LS_SE0;
      bit_phase_q <= 2'd0;
    end else if (link_reset_i) begin
      state_q     <= LS_SE0;
      bit_phase_q <= 2'd0;
    end else begin
      state_q     <= state_d;
      bit_phase_q <= bit_phase_d;
    end
  end

  assign symbol_o = state_q;

  // phase 1 sits in the middle of the bit, away from both edges
  assign symbol_valid_o = (bit_phase_q == 2'd1);
  assign bit_strobe_o   = (bit_phase_q == 2'd2);

endmodule

/* rtl/usb_rx_packet_framer.sv */
//////////////////////////////
// symbol history, sync and EOP detection, NRZI decode,
// bit-stuff removal and stuffing error flag
//////////////////////////////
`timescale 1ns/1ns
`include "usb_rx_config.svh"

module usb_rx_packet_framer import usb_rx_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        link_reset_i,
  input  line_state_e symbol_i,
  input  logic        symbol_valid_i,
  output logic        pkt_start_o,
  output logic        pid_begin_o,
  output logic        pkt_end_o,
  output logic        rx_bit_o,
  output logic        rx_bit_valid_o,
  output logic        stuff_err_o,
  output logic        bitstuff_error_o
);

  logic [11:0] history_q, history_d;
  logic        in_packet_q, in_packet_d;
  logic        active_q, active_d;
  logic        se0_eop, see_eop, see_sop;
  logic        pid_begin, pkt_end;
  logic        din, dvalid_raw, dvalid;
  logic [6:0]  ones_q, ones_d;
  logic        seventh_one;
  logic        stuff_err_q, stuff_err_d;

  //////////////////////////////
  // packet boundaries
  //////////////////////////////

  // two bits per mid-bit sample, newest in the low bits
  assign history_d = symbol_valid_i ? {history_q[9:0], symbol_i[1:0]} : history_q;

  // two SE0 samples in a row close the packet, so does a stuffing error
  assign se0_eop = (history_q[3:0] == 4'b0000);
  assign see_eop = se0_eop || stuff_err_q;

  // a J followed by K is the first edge of a sync
  assign see_sop = (history_q[3:0] == 4'b10_01) && !in_packet_q;

  // in_packet only keeps the start strobe to one pulse per packet
  assign in_packet_d = (se0_eop || pkt_end) ? 1'b0 :
                       see_sop              ? 1'b1 : in_packet_q;

  // the packet turns active on the sample that completes the sync
  // and inactive on the sample after EOP was seen
  always_comb begin
    active_d = active_q;
    if (symbol_valid_i) begin
      if (!active_q && history_q == `USB_SYNC_HISTORY) begin
        active_d = 1'b1;
      end else if (active_q && see_eop) begin
        active_d = 1'b0;
      end
    end
  end

  assign pid_begin = active_d && !active_q;
  assign pkt_end   = !active_d && active_q;

  //////////////////////////////
  // NRZI decode and destuffing
  //////////////////////////////

  // no change between two samples is a one, a change is a zero
  assign din = (history_q[3:2] == history_q[1:0]);

  // both samples must be J or K, anything with SE0 in it carries no data
  assign dvalid_raw = active_q && symbol_valid_i && (^history_q[3:2]) && (^history_q[1:0]);

  // the bit after a full run of ones is the stuffed zero and never goes out
  assign dvalid = dvalid_raw && !(&ones_q[`USB_STUFF_LIMIT-1:0]);

  // seven ones means the transmitter missed a stuffed zero
  assign seventh_one = &ones_q;

  always_comb begin
    ones_d = ones_q;
    if (pkt_end) begin
      ones_d = '0;
    end else if (dvalid_raw) begin
      ones_d = {ones_q[5:0], din};
    end
  end

  // the error sticks until the next packet so the checker can still see it at EOP
  always_comb begin
    stuff_err_d = stuff_err_q;
    if (pid_begin) begin
      stuff_err_d = 1'b0;
    end else if (seventh_one && dvalid_raw) begin
      stuff_err_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      history_q   <= `USB_HISTORY_RESET;
      in_packet_q <= 1'b0;
      active_q    <= 1'b0;
      ones_q      <= '0;
      stuff_err_q <= 1'b0;
    end else if (link_reset_i) begin
      history_q   <= `USB_HISTORY_RESET;
      in_packet_q <= 1'b0;
      active_q    <= 1'b0;
      ones_q      <= '0;
      stuff_err_q <= 1'b0;
    end else begin
      history_q   <= history_d;
      in_packet_q <= in_packet_d;
      active_q    <= active_d;
      ones_q      <= ones_d;
      stuff_err_q <= stuff_err_d;
    end
  end

  assign pkt_start_o      = see_sop;
  assign pid_begin_o      = pid_begin;
  assign pkt_end_o        = pkt_end;
  assign rx_bit_o         = din;
  assign rx_bit_valid_o   = dvalid;
  assign stuff_err_o      = stuff_err_q;
  assign bitstuff_error_o = stuff_err_q && pkt_end;

endmodule

/* rtl/usb_rx_pid_crc_check.sv */
//////////////////////////////
// pid capture and check, crc5 and crc16 engines,
// payload length count, error pulses and packet validity
//////////////////////////////
`timescale 1ns/1ns
`include "usb_rx_config.svh"

module usb_rx_pid_crc_check import usb_rx_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      link_reset_i,
  input  logic      rx_bit_i,
  input  logic      rx_bit_valid_i,
  input  logic      pid_begin_i,
  input  logic      pkt_end_i,
  input  logic      stuff_err_i,
  output usb_pid_t  pid_o,
  output pkt_kind_e pkt_kind_o,
  output logic      payload_bit_valid_o,
  output logic      valid_pid_o,
  output logic      valid_packet_o,
  output logic      crc5_error_o,
  output logic      crc16_error_o,
  output logic      pid_error_o
);

  logic [8:0] pid_q, pid_d;
  logic       pid_complete, pid_valid;
  pkt_kind_e  kind;
  logic       payload_bit;
  crc5_t      crc5_q, crc5_d;
  crc16_t     crc16_q, crc16_d;
  logic       crc5_valid, crc16_valid;
  logic [3:0] len_q, len_d;
  logic       len16_q, len16_d;
  logic       token_len_ok, data_len_ok, handshake_len_ok;

  //////////////////////////////
  // pid
  //////////////////////////////

  // pid arrives LSB first, the sentinel reaches bit 0 with the eighth bit
  assign pid_complete = pid_q[0];

  // high nibble is the ones complement of the low nibble
  assign pid_valid = (pid_q[4:1] == ~pid_q[8:5]);
  assign kind      = pkt_kind_e'(pid_q[2:1]);

  always_comb begin
    pid_d = pid_q;
    if (pid_begin_i) begin
      pid_d = `USB_PID_SENTINEL;
    end else if (rx_bit_valid_i && !pid_complete) begin
      pid_d = {rx_bit_i, pid_q[8:1]};
    end
  end

  // everything after the pid is payload, crc included
  assign payload_bit = rx_bit_valid_i && pid_complete;

  //////////////////////////////
  // crc and length
  //////////////////////////////

  assign crc5_valid  = (crc5_q == `USB_CRC5_RESIDUE);
  assign crc16_valid = (crc16_q == `USB_CRC16_RESIDUE);

  // both engines run on every payload bit, the packet kind picks the one that counts
  always_comb begin
    crc5_d  = crc5_q;
    crc16_d = crc16_q;
    if (pid_begin_i) begin
      crc5_d  = `USB_CRC5_SEED;
      crc16_d = `USB_CRC16_SEED;
    end else if (payload_bit) begin
      crc5_d  = {crc5_q[3:0], 1'b0} ^ ({5{rx_bit_i ^ crc5_q[4]}} & `USB_CRC5_POLY);
      crc16_d = {crc16_q[14:0], 1'b0} ^ ({16{rx_bit_i ^ crc16_q[15]}} & `USB_CRC16_POLY);
    end
  end

  // len16 latches once the 4-bit count has wrapped
  always_comb begin
    len_d   = len_q;
    len16_d = len16_q;
    if (pid_begin_i) begin
      len_d   = 4'd0;
      len16_d = 1'b0;
    end else if (payload_bit) begin
      len_d   = len_q + 4'd1;
      len16_d = len16_q || (&len_q);
    end
  end

  // a token is exactly 16 bits, data is whole bytes with at least the crc16
  assign token_len_ok     = len16_q && (len_q == 4'd0);
  assign data_len_ok      = len16_q && (len_q[2:0] == 3'd0);
  assign handshake_len_ok = !len16_q && (len_q == 4'd0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pid_q   <= '0;
      crc5_q  <= '0;
      crc16_q <= '0;
      len_q   <= '0;
      len16_q <= 1'b0;
    end else if (link_reset_i) begin
      pid_q   <= '0;
      crc5_q  <= '0;
      crc16_q <= '0;
      len_q   <= '0;
      len16_q <= 1'b0;
    end else begin
      pid_q   <= pid_d;
      crc5_q  <= crc5_d;
      crc16_q <= crc16_d;
      len_q   <= len_d;
      len16_q <= len16_d;
    end
  end

  //////////////////////////////
  // results
  //////////////////////////////

  assign pid_o               = pid_q[4:1];
  assign pkt_kind_o          = kind;
  assign payload_bit_valid_o = payload_bit;
  assign valid_pid_o         = pid_valid;

  assign valid_packet_o = pid_valid && !stuff_err_i &&
                          ((kind == KIND_HANDSHAKE && handshake_len_ok) ||
                           (kind == KIND_TOKEN && token_len_ok && crc5_valid) ||
                           (kind == KIND_DATA && data_len_ok && crc16_valid));

  // error pulses only line up with the end of the packet
  assign crc5_error_o  = pkt_end_i && (kind == KIND_TOKEN) && !crc5_valid;
  assign crc16_error_o = pkt_end_i && (kind == KIND_DATA) && !crc16_valid;
  assign pid_error_o   = pkt_end_i && !pid_valid;

endmodule

/* rtl/usb_rx_payload_decode.sv */
//////////////////////////////
// token field capture and data byte deserialisation
//////////////////////////////
`timescale 1ns/1ns

module usb_rx_payload_decode import usb_rx_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       link_reset_i,
  input  logic       rx_bit_i,
  input  logic       payload_bit_valid_i,
  input  logic       pid_begin_i,
  input  pkt_kind_e  pkt_kind_i,
  output usb_addr_t  addr_o,
  output usb_endp_t  endp_o,
  output frame_num_t frame_num_o,
  output logic       rx_data_put_o,
  output rx_byte_t   rx_data_o
);

  logic [11:0] token_q, token_d, token_next;
  logic        token_shift;
  usb_addr_t   addr_q;
  usb_endp_t   endp_q;
  frame_num_t  frame_q;
  logic [8:0]  byte_q, byte_d;
  logic        byte_full;

  // token payload is 11 bits LSB first, followed by the crc5 which is ignored here
  assign token_shift = payload_bit_valid_i && (pkt_kind_i == KIND_TOKEN) && !token_q[0];
  assign token_next  = {rx_bit_i, token_q[11:1]};

  always_comb begin
    token_d = token_q;
    if (pid_begin_i) begin
      token_d = 12'b1000_0000_0000;
    end else if (token_shift) begin
      token_d = token_next;
    end
  end

  // bytes are LSB first, the sentinel in bit 0 is also the put strobe
  assign byte_full = byte_q[0];

  always_comb begin
    byte_d = byte_q;
    if (pid_begin_i || byte_full) begin
      byte_d = 9'b1_0000_0000;
    end
    if (payload_bit_valid_i && (pkt_kind_i == KIND_DATA)) begin
      byte_d = {rx_bit_i, byte_q[8:1]};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      token_q <= '0;
      addr_q  <= '0;
      endp_q  <= '0;
      frame_q <= '0;
      byte_q  <= '0;
    end else if (link_reset_i) begin
      token_q <= '0;
      addr_q  <= '0;
      endp_q  <= '0;
      frame_q <= '0;
      byte_q  <= '0;
    end else begin
      token_q <= token_d;
      byte_q  <= byte_d;
      // fields load with the eleventh bit and then hold until the next token
      if (token_shift && token_next[0]) begin
        addr_q  <= token_next[7:1];
        endp_q  <= token_next[11:8];
        frame_q <= token_next[11:1];
      end
    end
  end

  assign addr_o        = addr_q;
  assign endp_o        = endp_q;
  assign frame_num_o   = frame_q;
  assign rx_data_put_o = byte_full;
  assign rx_data_o     = byte_q[8:1];

endmodule

/* rtl/usb_fs_rx.sv */
//////////////////////////////
// usb full-speed packet receiver top level,
// line recovery, framing, checking and payload stages
//////////////////////////////
`timescale 1ns/1ns

module usb_fs_rx import usb_rx_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       link_reset_i,
  input  logic       usb_dp_i,
  input  logic       usb_dn_i,
  output logic       bit_strobe_o,
  output logic       pkt_start_o,
  output logic       pkt_end_o,
  output usb_pid_t   pid_o,
  output usb_addr_t  addr_o,
  output usb_endp_t  endp_o,
  output frame_num_t frame_num_o,
  output logic       rx_data_put_o,
  output rx_byte_t   rx_data_o,
  output logic       valid_pid_o,
  output logic       valid_packet_o,
  output logic       crc5_error_o,
  output logic       crc16_error_o,
  output logic       pid_error_o,
  output logic       bitstuff_error_o
);

  line_state_e symbol;
  logic        symbol_valid;
  logic        rx_bit, rx_bit_valid;
  logic        pid_begin, pkt_end, stuff_err;
  logic        payload_bit_valid;
  pkt_kind_e   pkt_kind;

  // pair to mid-bit symbols
  usb_rx_line_recovery u_line_recovery (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .link_reset_i   (link_reset_i),
    .usb_dp_i       (usb_dp_i),
    .usb_dn_i       (usb_dn_i),
    .symbol_o       (symbol),
    .symbol_valid_o (symbol_valid),
    .bit_strobe_o   (bit_strobe_o)
  );

  // symbols to destuffed bits and packet boundaries
  usb_rx_packet_framer u_packet_framer (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .link_reset_i     (link_reset_i),
    .symbol_i         (symbol),
    .symbol_valid_i   (symbol_valid),
    .pkt_start_o      (pkt_start_o),
    .pid_begin_o      (pid_begin),
    .pkt_end_o        (pkt_end),
    .rx_bit_o         (rx_bit),
    .rx_bit_valid_o   (rx_bit_valid),
    .stuff_err_o      (stuff_err),
    .bitstuff_error_o (bitstuff_error_o)
  );

  usb_rx_pid_crc_check u_pid_crc_check (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .link_reset_i        (link_reset_i),
    .rx_bit_i            (rx_bit),
    .rx_bit_valid_i      (rx_bit_valid),
    .pid_begin_i         (pid_begin),
    .pkt_end_i           (pkt_end),
    .stuff_err_i         (stuff_err),
    .pid_o               (pid_o),
    .pkt_kind_o          (pkt_kind),
    .payload_bit_valid_o (payload_bit_valid),
    .valid_pid_o         (valid_pid_o),
    .valid_packet_o      (valid_packet_o),
    .crc5_error_o        (crc5_error_o),
    .crc16_error_o       (crc16_error_o),
    .pid_error_o         (pid_error_o)
  );

  // the payload stage sees only bits that follow a complete pid
  usb_rx_payload_decode u_payload_decode (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .link_reset_i        (link_reset_i),
    .rx_bit_i            (rx_bit),
    .payload_bit_valid_i (payload_bit_valid),
    .pid_begin_i         (pid_begin),
    .pkt_kind_i          (pkt_kind),
    .addr_o              (addr_o),
    .endp_o              (endp_o),
    .frame_num_o         (frame_num_o),
    .rx_data_put_o       (rx_data_put_o),
    .rx_data_o           (rx_data_o)
  );

  assign pkt_end_o = pkt_end;

endmodule

/* testbench/usb_line_driver.svh */
//////////////////////////////
// line driver for the receiver testbench: packet bit assembly,
// NRZI coding with bit stuffing onto the pair, bit strobe check, reference CRCs
//////////////////////////////
`ifndef USB_LINE_DRIVER_SVH
`define USB_LINE_DRIVER_SVH

// pair values as {D+, D-}
localparam logic [1:0] PAIR_J   = 2'b10;
localparam logic [1:0] PAIR_K   = 2'b01;
localparam logic [1:0] PAIR_SE0 = 2'b00;

// J bits before the sync and after the EOP
localparam int LEAD_BITS = 2;
localparam int IDLE_BITS = 8;

// packet bits after the sync, in the order they go on the line
bit tx_bits[$];

function automatic void clear_bits();
  tx_bits.delete();
endfunction

// append the low n bits of value, LSB first
function automatic void append_bits(input logic [15:0] value, input int n);
  for (int i = 0; i < n; i++) begin
    tx_bits.push_back(value[i]);
  end
endfunction

function automatic logic [15:0] reflect(input logic [15:0] value, input int width);
  logic [15:0] result;
  result = '0;
  for (int i = 0; i < width; i++) begin
    result[width-1-i] = value[i];
  end
  return result;
endfunction

// the register runs LSB first with the mirrored polynomial, so the
// complemented result goes out LSB first as well
function automatic logic [4:0] crc5_field(input logic [10:0] data);
  logic [4:0] crc;
  logic [4:0] poly;
  crc  = `USB_CRC5_SEED;
  poly = 5'(reflect(16'(`USB_CRC5_POLY), 5));
  for (int i = 0; i < 11; i++) begin
    crc = (crc[0] ^ data[i]) ? ((crc >> 1) ^ poly) : (crc >> 1);
  end
  return ~crc;
endfunction

// crc16 over whole bytes, low byte of the result is sent first
function automatic logic [15:0] crc16_field(input logic [7:0] data[$]);
  logic [15:0] crc;
  logic [15:0] poly;
  crc  = `USB_CRC16_SEED;
  poly = reflect(`USB_CRC16_POLY, 16);
  foreach (data[n]) begin
    for (int i = 0; i < 8; i++) begin
      crc = (crc[0] ^ data[n][i]) ? ((crc >> 1) ^ poly) : (crc >> 1);
    end
  end
  return ~crc;
endfunction

// each symbol sits on the pair for one bit time of four clocks
// once the bit phase has locked to a line edge the strobe lands on the last of them
task automatic drive_pair(input logic [1:0] pair, input bit strobe_check);
  usb_dp = pair[1];
  usb_dn = pair[0];
  for (int i = 1; i <= 4; i++) begin
    @(negedge clk);
    if (strobe_check) begin
      check_value("bit_strobe", "bit_strobe", 32'(i == 4), 32'(bit_strobe));
    end
  end
endtask

// a zero toggles the line and a one holds it, and with stuffing on a zero
// follows every run of six ones
task automatic send_packet(input bit stuff_en);
  logic [1:0] level;
  logic [7:0] sync_byte;
  int         ones;
  level     = PAIR_J;
  sync_byte = 8'h80;
  ones      = 0;
  @(negedge clk);
  repeat (LEAD_BITS) drive_pair(PAIR_J, 1'b0);
  // the first sync edge locks the bit phase, strobes count from the next bit on
  for (int i = 0; i < 8; i++) begin
    if (!sync_byte[i]) begin
      level = ~level;
    end
    drive_pair(level, i > 0);
  end
  foreach (tx_bits[n]) begin
    if (tx_bits[n]) begin
      ones++;
    end else begin
      level = ~level;
      ones  = 0;
    end
    drive_pair(level, 1'b1);
    if (stuff_en && ones == `USB_STUFF_LIMIT) begin
      level = ~level;
      ones  = 0;
      drive_pair(level, 1'b1);
    end
  end
  drive_pair(PAIR_SE0, 1'b1);
  drive_pair(PAIR_SE0, 1'b1);
  repeat (IDLE_BITS) drive_pair(PAIR_J, 1'b1);
endtask

`endif

/* testbench/tb_usb_fs_rx.sv */
//////////////////////////////
// testbench for the full-speed receiver: clock, reset,
// watchdog, directed packet tests and the closing report
//////////////////////////////
`timescale 1ns/1ns
`include "usb_rx_config.svh"

module tb_usb_fs_rx import usb_rx_pkg::*; ();

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 3;
  localparam int END_TIMEOUT  = 64;

  localparam usb_pid_t PID_OUT   = 4'b0001;
  localparam usb_pid_t PID_SOF   = 4'b0101;
  localparam usb_pid_t PID_ACK   = 4'b0010;
  localparam usb_pid_t PID_DATA0 = 4'b0011;

  logic clk, rst_n, link_reset, usb_dp, usb_dn;
  logic bit_strobe, pkt_start, pkt_end, rx_data_put, valid_pid, valid_packet;
  logic crc5_error, crc16_error, pid_error, bitstuff_error;
  usb_pid_t   pid;
  usb_addr_t  addr;
  usb_endp_t  endp;
  frame_num_t frame_num;
  rx_byte_t   rx_data;

  int          error_count = 0;
  int          check_count = 0;
  int          end_count   = 0;
  int          start_count = 0;
  int unsigned seed_draw;

  // everything the receiver reports, as seen on the pkt_end cycle
  logic [7:0] rx_bytes[$];
  usb_pid_t   end_pid;
  usb_addr_t  end_addr;
  usb_endp_t  end_endp;
  frame_num_t end_frame;
  logic [5:0] end_flags;
  int         end_starts = 0;

  `include "usb_line_driver.svh"

  // lead-in, sync, pid, 8 data bytes, crc16, stuffing, EOP and idle all fit
  localparam int MAX_PACKET_BITS = 128;
  localparam int NUM_PACKETS     = 11;
  localparam int WATCHDOG_NS = (NUM_PACKETS * MAX_PACKET_BITS * 4 + 1000) * CLK_PERIOD;

  usb_fs_rx usb_fs_rx_inst (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .link_reset_i     (link_reset),
    .usb_dp_i         (usb_dp),
    .usb_dn_i         (usb_dn),
    .bit_strobe_o     (bit_strobe),
    .pkt_start_o      (pkt_start),
    .pkt_end_o        (pkt_end),
    .pid_o            (pid),
    .addr_o           (addr),
    .endp_o           (endp),
    .frame_num_o      (frame_num),
    .rx_data_put_o    (rx_data_put),
    .rx_data_o        (rx_data),
    .valid_pid_o      (valid_pid),
    .valid_packet_o   (valid_packet),
    .crc5_error_o     (crc5_error),
    .crc16_error_o    (crc16_error),
    .pid_error_o      (pid_error),
    .bitstuff_error_o (bitstuff_error)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
    $display("Verification failed");
    $finish;
  end

  // outputs come straight from flops, so the falling edge sees them settled
  always @(negedge clk) begin
    if (rx_data_put) begin
      rx_bytes.push_back(rx_data);
    end
    if (pkt_start) begin
      start_count++;
    end
    if (pkt_end) begin
      end_pid    = pid;
      end_addr   = addr;
      end_endp   = endp;
      end_frame  = frame_num;
      end_flags  = {valid_pid, valid_packet, crc5_error, crc16_error, pid_error,
                    bitstuff_error};
      end_starts = start_count;
      end_count++;
    end
  end

  task automatic check_value(input string test_name, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("** Error %s: %s expected %0h actual %0h", test_name, field, expected, actual);
    end
  endtask

  task automatic wait_packet_end(input string test_name, input int ends_before);
    int cycles;
    cycles = 0;
    while (end_count == ends_before && cycles < END_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (end_count == ends_before) begin
      error_count++;
      $display("** Error %s: the receiver never signalled the end of the packet", test_name);
    end
  endtask

  task automatic transfer(input string test_name, input bit stuff_en);
    int ends_before;
    int starts_before;
    ends_before   = end_count;
    starts_before = start_count;
    rx_bytes.delete();
    send_packet(stuff_en);
    wait_packet_end(test_name, ends_before);
    // one J to K edge of the sync opens the packet, nothing else until its end
    check_value(test_name, "pkt_start pulses", 32'd1, 32'(end_starts - starts_before));
  endtask

  // order is valid_pid, valid_packet, crc5, crc16, pid error, stuffing error
  task automatic check_end_flags(input string test_name, input logic [5:0] expected);
    check_value(test_name, "end flags", 32'(expected), 32'(end_flags));
  endtask

  function automatic void build_token(input usb_pid_t pid_value, input logic [10:0] field);
    clear_bits();
    append_bits(16'({~pid_value, pid_value}), 8);
    append_bits(16'(field), 11);
    append_bits(16'(crc5_field(field)), 5);
  endfunction

  function automatic void build_data(input logic [7:0] data[$], input bit corrupt);
    logic [15:0] crc;
    crc = crc16_field(data);
    // a single flipped bit is always caught by the crc
    if (corrupt) begin
      crc[3] = ~crc[3];
    end
    clear_bits();
    append_bits(16'({~PID_DATA0, PID_DATA0}), 8);
    foreach (data[n]) begin
      append_bits(16'(data[n]), 8);
    end
    append_bits(crc, 16);
  endfunction

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic test_out_token();
    usb_addr_t a;
    usb_endp_t e;
    a = 7'($urandom_range(1, 127));
    e = 4'($urandom_range(0, 15));
    build_token(PID_OUT, {e, a});
    transfer("out_token", 1'b1);
    check_end_flags("out_token", 6'b110000);
    check_value("out_token", "pid", 32'(PID_OUT), 32'(end_pid));
    check_value("out_token", "addr", 32'(a), 32'(end_addr));
    check_value("out_token", "endp", 32'(e), 32'(end_endp));
    check_value("out_token", "data puts", 32'd0, 32'(rx_bytes.size()));
  endtask

  task automatic test_sof_token();
    frame_num_t frame;
    frame = 11'($urandom);
    build_token(PID_SOF, frame);
    transfer("sof_token", 1'b1);
    check_end_flags("sof_token", 6'b110000);
    check_value("sof_token", "frame", 32'(frame), 32'(end_frame));
    // same token with one crc5 bit flipped on the line
    build_token(PID_SOF, frame);
    tx_bits[21] = ~tx_bits[21];
    transfer("sof_bad_crc5", 1'b1);
    check_end_flags("sof_bad_crc5", 6'b101000);
  endtask

  task automatic test_data_packet();
    logic [7:0]  data[$];
    logic [7:0]  expected[$];
    logic [15:0] crc;
    int          len;
    len = $urandom_range(1, 8);
    for (int i = 0; i < len; i++) begin
      data.push_back(8'($urandom));
    end
    crc      = crc16_field(data);
    expected = data;
    expected.push_back(crc[7:0]);
    expected.push_back(crc[15:8]);
    build_data(data, 1'b0);
    transfer("data0", 1'b1);
    check_end_flags("data0", 6'b110000);
    check_value("data0", "byte count", 32'(expected.size()), 32'(rx_bytes.size()));
    foreach (expected[n]) begin
      if (n < rx_bytes.size()) begin
        check_value("data0", "byte", 32'(expected[n]), 32'(rx_bytes[n]));
      end
    end
    build_data(data, 1'b1);
    transfer("data0_bad_crc16", 1'b1);
    check_end_flags("data0_bad_crc16", 6'b100100);
  endtask

  task automatic test_bad_pid_and_ack();
    // check nibble equals the pid nibble, kind bits say handshake
    clear_bits();
    append_bits(16'h0022, 8);
    transfer("bad_pid", 1'b1);
    check_end_flags("bad_pid", 6'b000010);
    clear_bits();
    append_bits(16'({~PID_ACK, PID_ACK}), 8);
    transfer("ack", 1'b1);
    check_end_flags("ack", 6'b110000);
    check_value("ack", "pid", 32'(PID_ACK), 32'(end_pid));
    check_value("ack", "data puts", 32'd0, 32'(rx_bytes.size()));
  endtask

  task automatic test_bitstuff_error();
    // FE then 00 puts seven ones on the line with no stuffed zero
    clear_bits();
    append_bits(16'({~PID_DATA0, PID_DATA0}), 8);
    append_bits(16'h00FE, 16);
    transfer("bitstuff", 1'b0);
    check_value("bitstuff", "bitstuff_error", 32'd1, 32'(end_flags[0]));
    check_value("bitstuff", "valid_packet", 32'd0, 32'(end_flags[4]));
    clear_bits();
    append_bits(16'({~PID_ACK, PID_ACK}), 8);
    transfer("ack_after_bitstuff", 1'b1);
    check_end_flags("ack_after_bitstuff", 6'b110000);
    check_value("ack_after_bitstuff", "pid", 32'(PID_ACK), 32'(end_pid));
  endtask

  task automatic test_link_reset();
    usb_addr_t a;
    usb_endp_t e;
    a = 7'($urandom_range(1, 127));
    e = 4'($urandom_range(1, 15));
    build_token(PID_OUT, {e, a});
    transfer("pre_link_reset", 1'b1);
    check_value("pre_link_reset", "addr", 32'(a), 32'(end_addr));
    @(negedge clk);
    link_reset = 1'b1;
    repeat (2) @(negedge clk);
    link_reset = 1'b0;
    @(negedge clk);
    check_value("link_reset", "addr", 32'd0, 32'(addr));
    check_value("link_reset", "endp", 32'd0, 32'(endp));
    check_value("link_reset", "frame", 32'd0, 32'(frame_num));
    check_value("link_reset", "pid", 32'd0, 32'(pid));
    // the receiver must still work after the link reset
    a = 7'($urandom_range(1, 127));
    e = 4'($urandom_range(0, 15));
    build_token(PID_OUT, {e, a});
    transfer("post_link_reset", 1'b1);
    check_end_flags("post_link_reset", 6'b110000);
    check_value("post_link_reset", "addr", 32'(a), 32'(end_addr));
    check_value("post_link_reset", "endp", 32'(e), 32'(end_endp));
  endtask

  initial begin
    seed_draw  = $urandom(34);
    rst_n      = 1'b0;
    link_reset = 1'b0;
    usb_dp     = 1'b1;
    usb_dn     = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    test_out_token();
    test_sof_token();
    test_data_packet();
    test_bad_pid_and_ack();
    test_bitstuff_error();
    test_link_reset();

    $display("checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+rtl
+incdir+testbench
rtl/usb_rx_pkg.sv
rtl/usb_rx_line_recovery.sv
rtl/usb_rx_packet_framer.sv
rtl/usb_rx_pid_crc_check.sv
rtl/usb_rx_payload_decode.sv
rtl/usb_fs_rx.sv
testbench/tb_usb_fs_rx.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the receiver testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_usb_fs_rx -f compile.f --Mdir obj_dir

sim_output=$(./obj_dir/Vtb_usb_fs_rx)
echo "$sim_output"

if echo "$sim_output" | grep -qx "Verification passed"; then
  exit 0
fi
exit 1
